/* pkt_gmii_tx.f */
+incdir+hw
hw/gmii_tx_pkg.sv
hw/word_buffer.sv
hw/frame_sequencer.sv
hw/byte_serializer.sv
hw/gmii_tx_top.sv
tb/tb_clock_gen.sv
tb/gmii_tx_tb.sv

/* Bender.yml */
package:
  name: pkt_gmii_tx

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/gmii_tx_pkg.sv
      - hw/word_buffer.sv
      - hw/frame_sequencer.sv
      - hw/byte_serializer.sv
      - hw/gmii_tx_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/tb_clock_gen.sv
      - tb/gmii_tx_tb.sv

/* tb/gmii_tx_tb.sv */
// testbench for the gmii transmit converter
// random frames go in as packet words, the byte stream is
// checked against a byte queue by concurrent assertions

`include "gmii_tx_config.svh"

module gmii_tx_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int n_frames    = 20;
    localparam int ifg         = `GMII_TX_IFG_CYCLES;
    localparam int word_bytes  = `GMII_TX_WORD_BYTES;
    localparam int byte_w      = `GMII_TX_BYTE_W;
    localparam int watchdog_ns = n_frames * (8 * 16 + 40) * 4 + 2000;  // longest frames + slack
    localparam int drain_limit = 4 * word_bytes + 2 * ifg;  // buffered words plus one gap

    logic                   clk;
    logic                   rst_n;
    gmii_tx_pkg::pkt_word_t tx_word;
    logic                   tx_wr;
    logic                   rd_req;
    logic                   tx_finish;
    logic [byte_w-1:0]      rx_data;
    logic                   rx_wr;
    logic                   exp_finish;
    bit                     word_is_last;   // word on the input closes its frame

    logic [byte_w-1:0] exp_bytes [$];   // msb byte of each word first
    int                frame_lens [$];
    logic [byte_w-1:0] exp_head;
    bit                exp_avail;
    int                exp_count;
    int                frame_left;      // bytes still owed by the frame on the line
    int                idle_run;        // idle cycles since the last byte
    int                frames_done;
    bit                end_check;

    tb_clock_gen tb_clock_gen_i (.o_clk(clk), .o_rst_n(rst_n));

    gmii_tx_top gmii_tx_top_i (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .i_data          (tx_word),
        .i_data_wr       (tx_wr),
        .o_pkt_rd_req    (rd_req),
        .o_pkt_tx_finish (tx_finish),
        .o_data          (rx_data),
        .o_data_wr       (rx_wr)
    );

    assign exp_finish = tx_wr && word_is_last;

    task automatic stop_on_failure();
        $display("Test failures found");
        $fatal(1, "run stopped at the first failing check");
    endtask

    function automatic void refresh_expected();
        exp_count = exp_bytes.size();
        exp_avail = exp_count > 0;
        exp_head  = exp_avail ? exp_bytes[0] : '0;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus

    task automatic send_word(input gmii_tx_pkg::pkt_word_t w, input int n_bytes,
                             input bit is_last);
        do begin
            @(posedge clk);
            #1;
            tx_wr = 1'b0;
        end while (!rd_req);        // strobe only while a slot is free
        tx_wr        = 1'b1;
        tx_word      = w;
        word_is_last = is_last;
        for (int b = 0; b < n_bytes; b++) begin
            exp_bytes.push_back(w.data[`GMII_TX_DATA_W-1-byte_w*b -: byte_w]);
        end
        refresh_expected();
    endtask

    task automatic send_frame();
        int                     n_words;
        int                     inv;
        bit                     last;
        gmii_tx_pkg::pkt_word_t w;
        n_words = 2 + ($urandom % 7);
        inv     = $urandom % 16;
        frame_lens.push_back(n_words * word_bytes - inv);
        for (int i = 0; i < n_words; i++) begin
            last      = (i == n_words - 1);
            w.data    = {$urandom, $urandom, $urandom, $urandom};
            w.inv_cnt = last ? 4'(inv) : 4'd0;
            if (i == 0) begin
                w.flag = gmii_tx_pkg::flag_first;
            end else if (last) begin
                w.flag = gmii_tx_pkg::flag_last;
            end else begin
                w.flag = gmii_tx_pkg::flag_middle;
            end
            send_word(w, last ? word_bytes - inv : word_bytes, last);
        end
    endtask

    initial begin
        int drain_cycles;
        tx_wr        = 1'b0;
        tx_word      = '0;
        word_is_last = 1'b0;
        frame_left   = 0;
        idle_run     = ifg;             // line counts as idle long enough before frame 1
        frames_done  = 0;
        end_check    = 1'b0;
        drain_cycles = 0;
        refresh_expected();
        void'($urandom(32'h992b));
        wait (rst_n === 1'b1);
        for (int f = 0; f < n_frames; f++) begin
            send_frame();
        end
        @(posedge clk);
        #1 tx_wr = 1'b0;
        // the last frame may still sit in the buffer or wait out a gap
        while (frames_done < n_frames && drain_cycles < drain_limit) begin
            @(posedge clk);
            drain_cycles++;
        end
        repeat (ifg) @(posedge clk);
        #1 end_check = 1'b1;
        @(posedge clk);
        #1 end_check = 1'b0;
        @(posedge clk);
        $display("All tests passed!");
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("timeout after %0d ns, %0d of %0d frames sent",
                 watchdog_ns, frames_done, n_frames);
        stop_on_failure();
    end

    ////////////////////////////////////////////////////////////
    // output tracking, one step per rising edge

    always @(posedge clk) begin
        if (rst_n) begin
            if (rx_wr) begin
                if (frame_left == 0 && frame_lens.size() > 0) begin
                    frame_left = frame_lens.pop_front();    // first byte of a new frame
                end
                if (frame_left > 0) begin
                    frame_left--;
                    if (frame_left == 0) begin
                        frames_done++;
                    end
                end
                if (exp_avail) begin
                    void'(exp_bytes.pop_front());
                end
                idle_run = 0;
            end else if (idle_run < 1000) begin
                idle_run++;
            end
            refresh_expected();
        end
    end

    ////////////////////////////////////////////////////////////
    // checks

    a_reset_values : assert property (@(posedge clk) !rst_n |=> (!rx_wr && !tx_finish && rd_req))
    else begin
        $display("outputs left their reset values at %0t ns", $time);
        stop_on_failure();
    end

    a_finish_pulse : assert property (@(posedge clk) disable iff (!rst_n) tx_finish == exp_finish)
    else begin
        $display("mismatch at %0t ns: o_pkt_tx_finish = %b, expected %b", $time,
                 $sampled(tx_finish), $sampled(exp_finish));
        stop_on_failure();
    end

    a_byte_expected : assert property (@(posedge clk) disable iff (!rst_n) rx_wr |-> exp_avail)
    else begin
        $display("a byte came out at %0t ns although no byte was outstanding", $time);
        stop_on_failure();
    end

    a_byte_value : assert property (
        @(posedge clk) disable iff (!rst_n) (rx_wr && exp_avail) |-> (rx_data == exp_head)
    ) else begin
        $display("mismatch at %0t ns: o_data = %02h, expected %02h", $time,
                 $sampled(rx_data), $sampled(exp_head));
        stop_on_failure();
    end

    // last byte of a frame must be followed by an idle cycle
    a_frame_end : assert property (
        @(posedge clk) disable iff (!rst_n) (rx_wr && frame_left == 1) |=> !rx_wr
    ) else begin
        $display("frame %0d ran past its byte count at %0t ns", frames_done, $time);
        stop_on_failure();
    end

    a_no_split : assert property (
        @(posedge clk) disable iff (!rst_n) (rx_wr && frame_left > 0) |-> (idle_run < ifg)
    ) else begin
        $display("frame %0d was cut short, a gap opened inside it at %0t ns",
                 frames_done + 1, $time);
        stop_on_failure();
    end

    a_gap_length : assert property (
        @(posedge clk) disable iff (!rst_n) (rx_wr && frame_left == 0) |-> (idle_run >= ifg)
    ) else begin
        $display("gap of %0d cycles before frame %0d at %0t ns is shorter than %0d",
                 $sampled(idle_run), frames_done + 1, $time, ifg);
        stop_on_failure();
    end

    a_all_sent : assert property (
        @(posedge clk) end_check |-> (exp_count == 0 && frames_done == n_frames)
    ) else begin
        $display("run ended with %0d expected bytes unsent and %0d of %0d frames done",
                 $sampled(exp_count), $sampled(frames_done), n_frames);
        stop_on_failure();
    end

endmodule

/* tb/tb_clock_gen.sv */
// clock and reset source for the testbench
// 4 ns clock, active low reset over the first two rising edges

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    initial begin
        o_rst_n = 1'b0;
        repeat (2) @(posedge o_clk);
        #1 o_rst_n = 1'b1;      // released just after the second edge
    end

endmodule

/* hw/gmii_tx_top.sv */
// gmii transmit converter for one port
// 134-bit packet words in, gmii style byte stream out

`include "gmii_tx_config.svh"

module gmii_tx_top (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  gmii_tx_pkg::pkt_word_t     i_data,
    input  logic                       i_data_wr,
    output logic                       o_pkt_rd_req,
    output logic                       o_pkt_tx_finish,
    output logic [`GMII_TX_BYTE_W-1:0] o_data,
    output logic                       o_data_wr
);

    ////////////////////////////////////////////////////////////
    // internal connections

    logic                       head_valid;
    gmii_tx_pkg::pkt_word_t     head_word;
    logic                       pop;
    logic                       ser_ready;
    logic                       load;
    logic [`GMII_TX_DATA_W-1:0] load_data;
    gmii_tx_pkg::byte_cnt_t     load_count;

    word_buffer word_buffer_i (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_data_wr       (i_data_wr),
        .i_data          (i_data),
        .i_pop           (pop),
        .o_head_valid    (head_valid),
        .o_head_word     (head_word),
        .o_pkt_rd_req    (o_pkt_rd_req),
        .o_pkt_tx_finish (o_pkt_tx_finish)
    );

    frame_sequencer frame_sequencer_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_head_valid (head_valid),
        .i_head_word  (head_word),
        .i_ser_ready  (ser_ready),
        .o_pop        (pop),
        .o_load       (load),
        .o_load_data  (load_data),
        .o_load_count (load_count)
    );

    byte_serializer byte_serializer_i (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_load       (load),
        .i_load_data  (load_data),
        .i_load_count (load_count),
        .o_ready      (ser_ready),
        .o_data       (o_data),
        .o_data_wr    (o_data_wr)
    );

endmodule

/* hw/byte_serializer.sv */
// word to byte shifter
// sends the loaded word msb byte first, one byte per cycle

`include "gmii_tx_config.svh"

module byte_serializer (
    input  logic                       i_clk,
    input  logic                       i_rst_n,
    input  logic                       i_load,
    input  logic [`GMII_TX_DATA_W-1:0] i_load_data,
    input  gmii_tx_pkg::byte_cnt_t     i_load_count,
    output logic                       o_ready,
    output logic [`GMII_TX_BYTE_W-1:0] o_data,
    output logic                       o_data_wr
);

    localparam int data_w = `GMII_TX_DATA_W;
    localparam int byte_w = `GMII_TX_BYTE_W;

    logic [data_w-1:0]      shift_q;
    gmii_tx_pkg::byte_cnt_t cnt_q;      // bytes still to send, current one included

    ////////////////////////////////////////////////////////////
    // shift register

    always_ff @(posedge i_clk) begin
        if (i_load) begin
            shift_q <= i_load_data;
        end else if (cnt_q != '0) begin
            shift_q <= shift_q << byte_w;   // next byte moves to the top
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt_q <= '0;
        end else if (i_load) begin
            cnt_q <= i_load_count;
        end else if (cnt_q != '0) begin
            cnt_q <= cnt_q - gmii_tx_pkg::byte_cnt_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////
    // byte output

    assign o_data    = shift_q[data_w-1 -: byte_w];
    assign o_data_wr = cnt_q != '0;

    // a new word may replace the final byte without a bubble
    assign o_ready = cnt_q <= gmii_tx_pkg::byte_cnt_t'(1);

    a_load_when_ready : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_load |-> o_ready
    );

endmodule

/* hw/frame_sequencer.sv */
// frame state machine
// hands buffered words to the serializer in frame order and
// holds the line idle for the inter-frame gap after each frame

`include "gmii_tx_config.svh"

module frame_sequencer (
    input  logic                          i_clk,
    input  logic                          i_rst_n,
    input  logic                          i_head_valid,
    input  gmii_tx_pkg::pkt_word_t        i_head_word,
    input  logic                          i_ser_ready,
    output logic                          o_pop,
    output logic                          o_load,
    output logic [`GMII_TX_DATA_W-1:0]    o_load_data,
    output gmii_tx_pkg::byte_cnt_t        o_load_count
);

    localparam int ifg_cycles = `GMII_TX_IFG_CYCLES;
    localparam int gap_w      = $clog2(ifg_cycles);

    typedef enum logic [1:0] {
        st_idle,    // waiting for a first word
        st_frame,   // feeding middle and last words
        st_drain,   // last word still being sent
        st_gap      // inter-frame gap
    } seq_state_t;

    seq_state_t       state_q;
    seq_state_t       next_state;
    logic [gap_w-1:0] gap_cnt_q;
    logic             head_first;
    logic             head_last;
    logic             gap_done;

    assign head_first = i_head_word.flag == gmii_tx_pkg::flag_first;
    assign head_last  = i_head_word.flag == gmii_tx_pkg::flag_last;
    assign gap_done   = gap_cnt_q == gap_w'(ifg_cycles - 1);

    ////////////////////////////////////////////////////////////
    // next state and load strobes

    always_comb begin
        next_state = state_q;
        o_load     = 1'b0;
        o_pop      = 1'b0;
        unique case (state_q)
            st_idle: begin
                if (i_head_valid && !head_first) begin
                    o_pop = 1'b1;                 // stray word cannot open a frame
                end else if (i_head_valid && i_ser_ready) begin
                    o_load     = 1'b1;
                    o_pop      = 1'b1;
                    next_state = st_frame;
                end
            end
            st_frame: begin
                if (i_head_valid && i_ser_ready) begin
                    o_load = 1'b1;
                    o_pop  = 1'b1;
                    if (head_last) begin
                        next_state = st_drain;
                    end
                end
            end
            st_drain: begin
                if (i_ser_ready) begin
                    next_state = st_gap;          // final byte goes out this cycle
                end
            end
            st_gap: begin
                if (gap_done) begin
                    next_state = st_idle;
                end
            end
            default: next_state = st_idle;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q   <= st_idle;
            gap_cnt_q <= '0;
        end else begin
            state_q   <= next_state;
            gap_cnt_q <= (state_q == st_gap) ? gap_cnt_q + 1'b1 : '0;
        end
    end

    // trim the tail on the last word only
    assign o_load_data  = i_head_word.data;
    assign o_load_count = head_last
        ? gmii_tx_pkg::byte_cnt_t'(`GMII_TX_WORD_BYTES)
          - gmii_tx_pkg::byte_cnt_t'(i_head_word.inv_cnt)
        : gmii_tx_pkg::byte_cnt_t'(`GMII_TX_WORD_BYTES);

    // during the gap the serializer is empty and nothing new is loaded
    a_gap_quiet : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        (state_q == st_gap) |-> (i_ser_ready && !o_load)
    );

endmodule

/* hw/word_buffer.sv */
// two-slot ping-pong store for packet words
// requests a new word while a slot is free and flags the
// last word of a packet as it is written

module word_buffer (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_data_wr,
    input  gmii_tx_pkg::pkt_word_t i_data,
    input  logic                   i_pop,
    output logic                   o_head_valid,
    output gmii_tx_pkg::pkt_word_t o_head_word,
    output logic                   o_pkt_rd_req,
    output logic                   o_pkt_tx_finish
);

    gmii_tx_pkg::pkt_word_t slot_q [2];
    logic [1:0]             valid_q;
    logic                   wr_ptr_q;   // next slot to fill
    logic                   rd_ptr_q;   // oldest filled slot

    ////////////////////////////////////////////////////////////
    // slot storage, payload only

    always_ff @(posedge i_clk) begin
        if (i_data_wr) begin
            slot_q[wr_ptr_q] <= i_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // occupancy and pointers

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q  <= 2'b00;
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
        end else begin
            // write and pop never touch the same slot in one cycle
            for (int i = 0; i < 2; i++) begin
                if (i_data_wr && (wr_ptr_q == 1'(i))) begin
                    valid_q[i] <= 1'b1;
                end else if (i_pop && (rd_ptr_q == 1'(i))) begin
                    valid_q[i] <= 1'b0;
                end
            end
            if (i_data_wr) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (i_pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
        end
    end

    assign o_head_valid = valid_q[rd_ptr_q];
    assign o_head_word  = slot_q[rd_ptr_q];

    // free slot means the source may send one more word
    assign o_pkt_rd_req    = ~(valid_q[0] & valid_q[1]);
    assign o_pkt_tx_finish = i_data_wr && (i_data.flag == gmii_tx_pkg::flag_last);

    // source must respect the read request
    a_no_write_when_full : assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        i_data_wr |-> !(valid_q[0] && valid_q[1])
    );

endmodule

/* hw/gmii_tx_pkg.sv */
// gmii transmit converter types
// packet word layout as delivered by the packet buffer

`include "gmii_tx_config.svh"

package gmii_tx_pkg;

    ////////////////////////////////////////////////////////////
    // position of a word inside its packet

    typedef enum logic [1:0] {
        flag_middle = 2'b00,
        flag_first  = 2'b01,
        flag_last   = 2'b10   // 2'b11 (single word) not supported
    } word_flag_t;

    ////////////////////////////////////////////////////////////
    // packet word, msb first: flag, invalid tail bytes, data

    typedef struct packed {
        word_flag_t                 flag;
        logic [3:0]                 inv_cnt;  // unused bytes at the tail of a last word
        logic [`GMII_TX_DATA_W-1:0] data;     // byte 0 sits in the top 8 bits
    } pkt_word_t;

    // bytes left to send in one word, 0 to 16
    typedef logic [$clog2(`GMII_TX_WORD_BYTES+1)-1:0] byte_cnt_t;

endpackage

/* hw/gmii_tx_config.svh */
// gmii transmit converter
// global widths, byte count and inter-frame gap length

`ifndef GMII_TX_CONFIG_SVH
`define GMII_TX_CONFIG_SVH

////////////////////////////////////////////////////////////
// word layout

`define GMII_TX_DATA_W      128   // payload bits per packet word
`define GMII_TX_WORD_BYTES  16    // payload bytes per packet word
`define GMII_TX_WORD_W      134   // flag + invalid count + payload

////////////////////////////////////////////////////////////
// byte side

`define GMII_TX_BYTE_W      8     // gmii data width

// minimum idle cycles between two frames
`define GMII_TX_IFG_CYCLES  22

`endif
